//--- Bender.yml
package:
  name: stg_id

sources:
  - src/id_pkg.sv
  - src/id_class_decode.sv
  - src/id_field_extract.sv
  - src/id_pipe_reg.sv
  - src/stg_id.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_stg_id.sv

//--- src/id_class_decode.sv
module id_class_decode (
    input  logic [id_pkg::data_w-1:0] instr,
    output logic                      sgn_en,
    output logic                      imm_en,
    output logic                      uses_flags,
    output logic                      has_tgt_gp,
    output logic                      tgt_gp_we,
    output logic                      has_src_gp,
    output logic                      has_tgt_sr,
    output logic                      tgt_sr_we,
    output logic                      has_src_sr
);

    id_pkg::id_opc_e opc;
    logic            is_branch;
    logic            cond_move;
    logic            sr_src_field;

    assign opc = id_pkg::id_opc_e'(instr[id_pkg::opc_lsb +: id_pkg::opc_w]);

    // Unknown opcodes fall through with every flag clear
    always_comb begin
        sgn_en       = 1'b0;
        imm_en       = 1'b0;
        is_branch    = 1'b0;
        cond_move    = 1'b0;
        has_tgt_gp   = 1'b0;
        tgt_gp_we    = 1'b0;
        has_src_gp   = 1'b0;
        has_tgt_sr   = 1'b0;
        tgt_sr_we    = 1'b0;
        sr_src_field = 1'b0;
        case (opc)
            id_pkg::opc_movur, id_pkg::opc_addur, id_pkg::opc_subur: begin
                tgt_gp_we  = 1'b1;
                has_tgt_gp = 1'b1;
                has_src_gp = 1'b1;
            end
            id_pkg::opc_cmpur: begin
                has_tgt_gp = 1'b1;
                has_src_gp = 1'b1;
            end
            id_pkg::opc_mccur: begin
                tgt_gp_we  = 1'b1;
                has_tgt_gp = 1'b1;
                has_src_gp = 1'b1;
                cond_move  = 1'b1;
            end
            id_pkg::opc_movui, id_pkg::opc_addui: begin
                tgt_gp_we  = 1'b1;
                has_tgt_gp = 1'b1;
                imm_en     = 1'b1;
            end
            id_pkg::opc_cmpui: begin
                has_tgt_gp = 1'b1;
                imm_en     = 1'b1;
            end
            id_pkg::opc_movsi, id_pkg::opc_addsi: begin
                tgt_gp_we  = 1'b1;
                has_tgt_gp = 1'b1;
                imm_en     = 1'b1;
                sgn_en     = 1'b1;
            end
            id_pkg::opc_jccui: begin
                is_branch = 1'b1;
                imm_en    = 1'b1;
            end
            // DRt holds the PC-relative offset
            id_pkg::opc_bccsr: begin
                is_branch  = 1'b1;
                sgn_en     = 1'b1;
                has_tgt_gp = 1'b1;
            end
            id_pkg::opc_bccso: begin
                is_branch = 1'b1;
                sgn_en    = 1'b1;
                imm_en    = 1'b1;
            end
            id_pkg::opc_srmovur: begin
                tgt_sr_we    = 1'b1;
                has_tgt_sr   = 1'b1;
                sr_src_field = 1'b1;
            end
            id_pkg::opc_sraddsi: begin
                tgt_sr_we  = 1'b1;
                has_tgt_sr = 1'b1;
                sgn_en     = 1'b1;
                imm_en     = 1'b1;
            end
            id_pkg::opc_srstso: begin
                has_tgt_sr   = 1'b1;
                sr_src_field = 1'b1;
                sgn_en       = 1'b1;
                imm_en       = 1'b1;
            end
            id_pkg::opc_srldso: begin
                tgt_sr_we    = 1'b1;
                has_tgt_sr   = 1'b1;
                sr_src_field = 1'b1;
                sgn_en       = 1'b1;
                imm_en       = 1'b1;
            end
            // Writes the return address into LR
            id_pkg::opc_syscall: begin
                tgt_sr_we  = 1'b1;
                has_tgt_sr = 1'b1;
                imm_en     = 1'b1;
            end
            id_pkg::opc_csrrd: begin
                tgt_gp_we  = 1'b1;
                has_tgt_gp = 1'b1;
            end
            id_pkg::opc_csrwr: begin
                has_src_gp = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // Branches and the conditional move read FL
    assign uses_flags = is_branch | cond_move;
    assign has_src_sr = sr_src_field | uses_flags;

    we_has_field: assert final ((!tgt_gp_we || has_tgt_gp) && (!tgt_sr_we || has_tgt_sr))
        else $error("write enable set for an opcode without a target field");

endmodule

//--- src/id_field_extract.sv
module id_field_extract (
    input  logic [id_pkg::data_w-1:0]  instr,
    input  logic                       has_tgt_gp,
    input  logic                       has_src_gp,
    input  logic                       has_tgt_sr,
    input  logic                       has_src_sr,
    input  logic                       uses_flags,
    output logic [id_pkg::imm12_w-1:0] imm12,
    output logic [id_pkg::imm14_w-1:0] imm14,
    output logic [id_pkg::cc_w-1:0]    cc,
    output logic [id_pkg::gp_w-1:0]    tgt_gp,
    output logic [id_pkg::gp_w-1:0]    src_gp,
    output logic [id_pkg::sr_w-1:0]    tgt_sr,
    output logic [id_pkg::sr_w-1:0]    src_sr
);

    id_pkg::id_opc_e opc;

    assign opc = id_pkg::id_opc_e'(instr[id_pkg::opc_lsb +: id_pkg::opc_w]);

    // Immediate width depends on the opcode
    always_comb begin
        imm12 = '0;
        imm14 = '0;
        case (opc)
            id_pkg::opc_movui, id_pkg::opc_addui, id_pkg::opc_cmpui,
            id_pkg::opc_movsi, id_pkg::opc_addsi,
            id_pkg::opc_jccui, id_pkg::opc_bccso,
            id_pkg::opc_srstso, id_pkg::opc_srldso,
            id_pkg::opc_syscall: begin
                imm12 = instr[id_pkg::imm_lsb +: id_pkg::imm12_w];
            end
            id_pkg::opc_sraddsi: begin
                imm14 = instr[id_pkg::imm_lsb +: id_pkg::imm14_w];
            end
            default: begin
            end
        endcase
    end

    // Condition code slice per encoding
    always_comb begin
        cc = '0;
        case (opc)
            id_pkg::opc_jccui, id_pkg::opc_bccso: begin
                cc = instr[id_pkg::cc_hi_lsb +: id_pkg::cc_w];
            end
            id_pkg::opc_bccsr: begin
                cc = instr[id_pkg::cc_mid_lsb +: id_pkg::cc_w];
            end
            id_pkg::opc_mccur: begin
                cc = instr[id_pkg::cc_lo_lsb +: id_pkg::cc_w];
            end
            default: begin
            end
        endcase
    end

    assign tgt_gp = has_tgt_gp ? instr[id_pkg::tgt_gp_lsb +: id_pkg::gp_w] : '0;
    assign src_gp = has_src_gp ? instr[id_pkg::src_gp_lsb +: id_pkg::gp_w] : '0;

    // SYSCALL writes LR, KRET reads it back
    always_comb begin
        if ((opc == id_pkg::opc_syscall) || (opc == id_pkg::opc_kret)) begin
            tgt_sr = id_pkg::sr_idx_lr;
        end else if (has_tgt_sr) begin
            tgt_sr = instr[id_pkg::tgt_sr_lsb +: id_pkg::sr_w];
        end else begin
            tgt_sr = '0;
        end
    end

    // Flag consumers read FL implicitly
    always_comb begin
        if (!has_src_sr) begin
            src_sr = '0;
        end else if (uses_flags) begin
            src_sr = id_pkg::sr_idx_fl;
        end else begin
            src_sr = instr[id_pkg::src_sr_lsb +: id_pkg::sr_w];
        end
    end

endmodule

//--- src/id_pipe_reg.sv
module id_pipe_reg #(
    parameter int addr_w = 16
) (
    input  logic                       iw_clk,
    input  logic                       iw_rst,
    input  logic                       flush,
    input  logic                       stall,
    input  logic [addr_w-1:0]          pc_d,
    input  logic [id_pkg::data_w-1:0]  instr_d,
    input  logic                       sgn_en_d,
    input  logic                       imm_en_d,
    input  logic                       has_src_gp_d,
    input  logic                       tgt_gp_we_d,
    input  logic                       has_src_sr_d,
    input  logic                       tgt_sr_we_d,
    input  logic [id_pkg::imm12_w-1:0] imm12_d,
    input  logic [id_pkg::imm14_w-1:0] imm14_d,
    input  logic [id_pkg::cc_w-1:0]    cc_d,
    input  logic [id_pkg::gp_w-1:0]    tgt_gp_d,
    input  logic [id_pkg::gp_w-1:0]    src_gp_d,
    input  logic [id_pkg::sr_w-1:0]    tgt_sr_d,
    input  logic [id_pkg::sr_w-1:0]    src_sr_d,
    output logic [addr_w-1:0]          pc,
    output logic [id_pkg::data_w-1:0]  instr,
    output logic [id_pkg::opc_w-1:0]   opc,
    output logic                       sgn_en,
    output logic                       imm_en,
    output logic                       has_src_gp,
    output logic                       tgt_gp_we,
    output logic                       has_src_sr,
    output logic                       tgt_sr_we,
    output logic [id_pkg::imm12_w-1:0] imm12,
    output logic [id_pkg::imm14_w-1:0] imm14,
    output logic [id_pkg::cc_w-1:0]    cc,
    output logic [id_pkg::gp_w-1:0]    tgt_gp,
    output logic [id_pkg::gp_w-1:0]    src_gp,
    output logic [id_pkg::sr_w-1:0]    tgt_sr,
    output logic [id_pkg::sr_w-1:0]    src_sr
);

    // Six single-bit flags plus the multi-bit fields
    localparam int pipe_w = addr_w + id_pkg::data_w + id_pkg::opc_w + 6
                          + id_pkg::imm12_w + id_pkg::imm14_w + id_pkg::cc_w
                          + 2 * id_pkg::gp_w + 2 * id_pkg::sr_w;

    logic [pipe_w-1:0] pipe_d;
    logic [pipe_w-1:0] pipe_q;

    assign pipe_d = {pc_d, instr_d, instr_d[id_pkg::opc_lsb +: id_pkg::opc_w],
                     sgn_en_d, imm_en_d, has_src_gp_d, tgt_gp_we_d,
                     has_src_sr_d, tgt_sr_we_d, imm12_d, imm14_d, cc_d,
                     tgt_gp_d, src_gp_d, tgt_sr_d, src_sr_d};

    // Flush takes priority over stall
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            pipe_q <= '0;
        end else if (flush) begin
            pipe_q <= '0;
        end else if (!stall) begin
            pipe_q <= pipe_d;
        end
    end

    assign {pc, instr, opc, sgn_en, imm_en, has_src_gp, tgt_gp_we,
            has_src_sr, tgt_sr_we, imm12, imm14, cc,
            tgt_gp, src_gp, tgt_sr, src_sr} = pipe_q;

    flush_kills_we: assert property (
        @(posedge iw_clk) disable iff (iw_rst)
        flush |=> (!tgt_gp_we && !tgt_sr_we)
    ) else $error("write enable survived a flush");

    stall_holds_instr: assert property (
        @(posedge iw_clk) disable iff (iw_rst)
        (stall && !flush) |=> $stable(instr)
    ) else $error("instr changed during a stall");

endmodule

//--- src/id_pkg.sv
package id_pkg;

    // Word and field widths
    localparam int data_w  = 24;
    localparam int opc_w   = 8;
    localparam int cc_w    = 4;
    localparam int gp_w    = 4;
    localparam int sr_w    = 2;
    localparam int imm12_w = 12;
    localparam int imm14_w = 14;

    // Lowest bit of each field in the instruction word
    localparam int opc_lsb    = 16;
    localparam int tgt_gp_lsb = 12;
    localparam int src_gp_lsb = 8;
    localparam int tgt_sr_lsb = 14;
    localparam int src_sr_lsb = 12;
    localparam int imm_lsb    = 0;

    // Condition code slices, upper for jumps, middle for BCCsr, lower for MCCur
    localparam int cc_hi_lsb  = 12;
    localparam int cc_mid_lsb = 8;
    localparam int cc_lo_lsb  = 4;

    // Fixed special register indices
    localparam logic [sr_w-1:0] sr_idx_lr = 2'd1;
    localparam logic [sr_w-1:0] sr_idx_fl = 2'd2;

    typedef enum logic [opc_w-1:0] {
        // Register ALU
        opc_movur   = 8'h00,
        opc_addur   = 8'h01,
        opc_subur   = 8'h02,
        opc_cmpur   = 8'h03,
        opc_mccur   = 8'h04,

        // Unsigned immediate
        opc_movui   = 8'h10,
        opc_addui   = 8'h11,
        opc_cmpui   = 8'h12,

        // Signed immediate
        opc_movsi   = 8'h20,
        opc_addsi   = 8'h21,

        // Branches
        opc_jccui   = 8'h30,
        opc_bccsr   = 8'h31,
        opc_bccso   = 8'h32,

        // SR micro-ops
        opc_srmovur = 8'h40,
        opc_sraddsi = 8'h41,
        opc_srstso  = 8'h42,
        opc_srldso  = 8'h43,

        // Kernel entry and return
        opc_syscall = 8'h50,
        opc_kret    = 8'h51,

        // CSR access
        opc_csrrd   = 8'h60,
        opc_csrwr   = 8'h61
    } id_opc_e;

endpackage

//--- src/stg_id.sv
module stg_id #(
    parameter int addr_w = 16
) (
    input  logic                       iw_clk,
    input  logic                       iw_rst,
    input  logic [addr_w-1:0]          pc,
    input  logic [id_pkg::data_w-1:0]  instr,
    input  logic                       flush,
    input  logic                       stall,
    output logic [addr_w-1:0]          id_pc,
    output logic [id_pkg::data_w-1:0]  id_instr,
    output logic [id_pkg::opc_w-1:0]   opc,
    output logic                       sgn_en,
    output logic                       imm_en,
    output logic                       has_src_gp,
    output logic                       tgt_gp_we,
    output logic                       has_src_sr,
    output logic                       tgt_sr_we,
    output logic [id_pkg::imm12_w-1:0] imm12,
    output logic [id_pkg::imm14_w-1:0] imm14,
    output logic [id_pkg::cc_w-1:0]    cc,
    output logic [id_pkg::gp_w-1:0]    tgt_gp,
    output logic [id_pkg::gp_w-1:0]    src_gp,
    output logic [id_pkg::sr_w-1:0]    tgt_sr,
    output logic [id_pkg::sr_w-1:0]    src_sr
);

    logic                       dec_sgn_en;
    logic                       dec_imm_en;
    logic                       dec_uses_flags;
    logic                       dec_has_tgt_gp;
    logic                       dec_tgt_gp_we;
    logic                       dec_has_src_gp;
    logic                       dec_has_tgt_sr;
    logic                       dec_tgt_sr_we;
    logic                       dec_has_src_sr;
    logic [id_pkg::imm12_w-1:0] dec_imm12;
    logic [id_pkg::imm14_w-1:0] dec_imm14;
    logic [id_pkg::cc_w-1:0]    dec_cc;
    logic [id_pkg::gp_w-1:0]    dec_tgt_gp;
    logic [id_pkg::gp_w-1:0]    dec_src_gp;
    logic [id_pkg::sr_w-1:0]    dec_tgt_sr;
    logic [id_pkg::sr_w-1:0]    dec_src_sr;

    id_class_decode i_class_decode (
        .instr      (instr),
        .sgn_en     (dec_sgn_en),
        .imm_en     (dec_imm_en),
        .uses_flags (dec_uses_flags),
        .has_tgt_gp (dec_has_tgt_gp),
        .tgt_gp_we  (dec_tgt_gp_we),
        .has_src_gp (dec_has_src_gp),
        .has_tgt_sr (dec_has_tgt_sr),
        .tgt_sr_we  (dec_tgt_sr_we),
        .has_src_sr (dec_has_src_sr)
    );

    id_field_extract i_field_extract (
        .instr      (instr),
        .has_tgt_gp (dec_has_tgt_gp),
        .has_src_gp (dec_has_src_gp),
        .has_tgt_sr (dec_has_tgt_sr),
        .has_src_sr (dec_has_src_sr),
        .uses_flags (dec_uses_flags),
        .imm12      (dec_imm12),
        .imm14      (dec_imm14),
        .cc         (dec_cc),
        .tgt_gp     (dec_tgt_gp),
        .src_gp     (dec_src_gp),
        .tgt_sr     (dec_tgt_sr),
        .src_sr     (dec_src_sr)
    );

    id_pipe_reg #(
        .addr_w (addr_w)
    ) i_pipe_reg (
        .iw_clk       (iw_clk),
        .iw_rst       (iw_rst),
        .flush        (flush),
        .stall        (stall),
        .pc_d         (pc),
        .instr_d      (instr),
        .sgn_en_d     (dec_sgn_en),
        .imm_en_d     (dec_imm_en),
        .has_src_gp_d (dec_has_src_gp),
        .tgt_gp_we_d  (dec_tgt_gp_we),
        .has_src_sr_d (dec_has_src_sr),
        .tgt_sr_we_d  (dec_tgt_sr_we),
        .imm12_d      (dec_imm12),
        .imm14_d      (dec_imm14),
        .cc_d         (dec_cc),
        .tgt_gp_d     (dec_tgt_gp),
        .src_gp_d     (dec_src_gp),
        .tgt_sr_d     (dec_tgt_sr),
        .src_sr_d     (dec_src_sr),
        .pc           (id_pc),
        .instr        (id_instr),
        .opc          (opc),
        .sgn_en       (sgn_en),
        .imm_en       (imm_en),
        .has_src_gp   (has_src_gp),
        .tgt_gp_we    (tgt_gp_we),
        .has_src_sr   (has_src_sr),
        .tgt_sr_we    (tgt_sr_we),
        .imm12        (imm12),
        .imm14        (imm14),
        .cc           (cc),
        .tgt_gp       (tgt_gp),
        .src_gp       (src_gp),
        .tgt_sr       (tgt_sr),
        .src_sr       (src_sr)
    );

endmodule

//--- stg_id.f
+incdir+tb
src/id_pkg.sv
src/id_class_decode.sv
src/id_field_extract.sv
src/id_pipe_reg.sv
src/stg_id.sv
tb/tb_stg_id.sv

//--- tb/stg_id_vectors.svh
// Columns: instr, flush, stall, expected flags {sgn_en, imm_en, has_src_gp, tgt_gp_we,
// has_src_sr, tgt_sr_we}, imm12, imm14, cc, {tgt_gp, src_gp}, {tgt_sr, src_sr}
localparam int n_rows = 30;

task automatic load_table();
    // Register ALU, compare, CSR access
    add_row(24'h005A3C, 1'b0, 1'b0, 6'b001100, 12'h000, 14'h0000, 4'h0, 8'h5A, 4'h0);
    add_row(24'h013C7E, 1'b0, 1'b0, 6'b001100, 12'h000, 14'h0000, 4'h0, 8'h3C, 4'h0);
    add_row(24'h02F0E1, 1'b0, 1'b0, 6'b001100, 12'h000, 14'h0000, 4'h0, 8'hF0, 4'h0);
    add_row(24'h0321FF, 1'b0, 1'b0, 6'b001000, 12'h000, 14'h0000, 4'h0, 8'h21, 4'h0);
    add_row(24'h047B9D, 1'b0, 1'b0, 6'b001110, 12'h000, 14'h0000, 4'h9, 8'h7B, 4'h2);
    add_row(24'h607123, 1'b0, 1'b0, 6'b000100, 12'h000, 14'h0000, 4'h0, 8'h70, 4'h0);
    add_row(24'h617123, 1'b0, 1'b0, 6'b001000, 12'h000, 14'h0000, 4'h0, 8'h01, 4'h0);
    // Immediates
    add_row(24'h104ABC, 1'b0, 1'b0, 6'b010100, 12'hABC, 14'h0000, 4'h0, 8'h40, 4'h0);
    add_row(24'h119FFF, 1'b0, 1'b0, 6'b010100, 12'hFFF, 14'h0000, 4'h0, 8'h90, 4'h0);
    add_row(24'h122345, 1'b0, 1'b0, 6'b010000, 12'h345, 14'h0000, 4'h0, 8'h20, 4'h0);
    add_row(24'h20E800, 1'b0, 1'b0, 6'b110100, 12'h800, 14'h0000, 4'h0, 8'hE0, 4'h0);
    add_row(24'h2117FF, 1'b0, 1'b0, 6'b110100, 12'h7FF, 14'h0000, 4'h0, 8'h10, 4'h0);
    // Branches read FL
    add_row(24'h30C123, 1'b0, 1'b0, 6'b010010, 12'h123, 14'h0000, 4'hC, 8'h00, 4'h2);
    add_row(24'h31D5A6, 1'b0, 1'b0, 6'b100010, 12'h000, 14'h0000, 4'h5, 8'hD0, 4'h2);
    add_row(24'h323F80, 1'b0, 1'b0, 6'b110010, 12'hF80, 14'h0000, 4'h3, 8'h00, 4'h2);
    // SR micro-ops, SYSCALL and KRET force LR
    add_row(24'h409000, 1'b0, 1'b0, 6'b000011, 12'h000, 14'h0000, 4'h0, 8'h00, 4'h9);
    add_row(24'h41B123, 1'b0, 1'b0, 6'b110001, 12'h000, 14'h3123, 4'h0, 8'h00, 4'h8);
    add_row(24'h427ABC, 1'b0, 1'b0, 6'b110010, 12'hABC, 14'h0000, 4'h0, 8'h00, 4'h7);
    add_row(24'h43C801, 1'b0, 1'b0, 6'b110011, 12'h801, 14'h0000, 4'h0, 8'h00, 4'hC);
    add_row(24'h50F456, 1'b0, 1'b0, 6'b010001, 12'h456, 14'h0000, 4'h0, 8'h00, 4'h4);
    add_row(24'h51FFFF, 1'b0, 1'b0, 6'b000000, 12'h000, 14'h0000, 4'h0, 8'h00, 4'h4);
    add_row(24'h7FFFFF, 1'b0, 1'b0, 6'b000000, 12'h000, 14'h0000, 4'h0, 8'h00, 4'h0);
    // Two stall rows hold the ADDsi result
    add_row(24'h213ABC, 1'b0, 1'b0, 6'b110100, 12'hABC, 14'h0000, 4'h0, 8'h30, 4'h0);
    add_row(24'h101234, 1'b0, 1'b1, 6'b110100, 12'hABC, 14'h0000, 4'h0, 8'h30, 4'h0);
    add_row(24'h101234, 1'b0, 1'b1, 6'b110100, 12'hABC, 14'h0000, 4'h0, 8'h30, 4'h0);
    add_row(24'h101234, 1'b0, 1'b0, 6'b010100, 12'h234, 14'h0000, 4'h0, 8'h10, 4'h0);
    // Flush with stall, then a capture and a plain flush
    add_row(24'h323F80, 1'b1, 1'b1, 6'b000000, 12'h000, 14'h0000, 4'h0, 8'h00, 4'h0);
    add_row(24'h047B9D, 1'b0, 1'b0, 6'b001110, 12'h000, 14'h0000, 4'h9, 8'h7B, 4'h2);
    add_row(24'h0321FF, 1'b1, 1'b0, 6'b000000, 12'h000, 14'h0000, 4'h0, 8'h00, 4'h0);
    add_row(24'h05ABCD, 1'b0, 1'b0, 6'b000000, 12'h000, 14'h0000, 4'h0, 8'h00, 4'h0);
endtask

//--- tb/tb_stg_id.sv
module tb_stg_id;

    localparam int addr_w = 16;

    `include "stg_id_vectors.svh"

    logic                       iw_clk;
    logic                       iw_rst;
    logic [addr_w-1:0]          pc;
    logic [id_pkg::data_w-1:0]  instr;
    logic                       flush;
    logic                       stall;
    logic [addr_w-1:0]          id_pc;
    logic [id_pkg::data_w-1:0]  id_instr;
    logic [id_pkg::opc_w-1:0]   opc;
    logic                       sgn_en;
    logic                       imm_en;
    logic                       has_src_gp;
    logic                       tgt_gp_we;
    logic                       has_src_sr;
    logic                       tgt_sr_we;
    logic [id_pkg::imm12_w-1:0] imm12;
    logic [id_pkg::imm14_w-1:0] imm14;
    logic [id_pkg::cc_w-1:0]    cc;
    logic [id_pkg::gp_w-1:0]    tgt_gp;
    logic [id_pkg::gp_w-1:0]    src_gp;
    logic [id_pkg::sr_w-1:0]    tgt_sr;
    logic [id_pkg::sr_w-1:0]    src_sr;

    logic [23:0]       vec_instr [0:n_rows-1];
    logic              vec_flush [0:n_rows-1];
    logic              vec_stall [0:n_rows-1];
    logic [5:0]        vec_flags [0:n_rows-1];
    logic [11:0]       vec_imm12 [0:n_rows-1];
    logic [13:0]       vec_imm14 [0:n_rows-1];
    logic [3:0]        vec_cc    [0:n_rows-1];
    logic [7:0]        vec_gp    [0:n_rows-1];
    logic [3:0]        vec_sr    [0:n_rows-1];
    logic [addr_w-1:0] vec_pc    [0:n_rows-1];
    logic [addr_w-1:0] exp_pc    [0:n_rows-1];
    logic [23:0]       exp_instr [0:n_rows-1];
    int                fill_idx;
    int                errors;
    int                checks;
    int                seed;

    stg_id #(
        .addr_w (addr_w)
    ) i_stg_id (
        .iw_clk     (iw_clk),
        .iw_rst     (iw_rst),
        .pc         (pc),
        .instr      (instr),
        .flush      (flush),
        .stall      (stall),
        .id_pc      (id_pc),
        .id_instr   (id_instr),
        .opc        (opc),
        .sgn_en     (sgn_en),
        .imm_en     (imm_en),
        .has_src_gp (has_src_gp),
        .tgt_gp_we  (tgt_gp_we),
        .has_src_sr (has_src_sr),
        .tgt_sr_we  (tgt_sr_we),
        .imm12      (imm12),
        .imm14      (imm14),
        .cc         (cc),
        .tgt_gp     (tgt_gp),
        .src_gp     (src_gp),
        .tgt_sr     (tgt_sr),
        .src_sr     (src_sr)
    );

    task automatic add_row(input logic [23:0] i, input logic f, input logic s,
                           input logic [5:0] fl, input logic [11:0] i12,
                           input logic [13:0] i14, input logic [3:0] c,
                           input logic [7:0] gp, input logic [3:0] sr);
        vec_instr[fill_idx] = i;
        vec_flush[fill_idx] = f;
        vec_stall[fill_idx] = s;
        vec_flags[fill_idx] = fl;
        vec_imm12[fill_idx] = i12;
        vec_imm14[fill_idx] = i14;
        vec_cc[fill_idx]    = c;
        vec_gp[fill_idx]    = gp;
        vec_sr[fill_idx]    = sr;
        fill_idx++;
    endtask

    task automatic compare(input string name, input logic [31:0] exp_val,
                           input logic [31:0] act_val);
        checks++;
        if (act_val !== exp_val) begin
            $display("FAIL %s expected %0h got %0h at time %0t", name, exp_val, act_val, $time);
            errors++;
        end
    endtask

    task automatic check_outputs(input logic [addr_w-1:0] e_pc, input logic [23:0] e_instr,
                                 input logic [5:0] e_flags, input logic [11:0] e_imm12,
                                 input logic [13:0] e_imm14, input logic [3:0] e_cc,
                                 input logic [7:0] e_gp, input logic [3:0] e_sr);
        compare("id_pc", e_pc, id_pc);
        compare("id_instr", e_instr, id_instr);
        compare("opc", e_instr[23:16], opc);
        compare("sgn_en", e_flags[5], sgn_en);
        compare("imm_en", e_flags[4], imm_en);
        compare("has_src_gp", e_flags[3], has_src_gp);
        compare("tgt_gp_we", e_flags[2], tgt_gp_we);
        compare("has_src_sr", e_flags[1], has_src_sr);
        compare("tgt_sr_we", e_flags[0], tgt_sr_we);
        compare("imm12", e_imm12, imm12);
        compare("imm14", e_imm14, imm14);
        compare("cc", e_cc, cc);
        compare("tgt_gp", e_gp[7:4], tgt_gp);
        compare("src_gp", e_gp[3:0], src_gp);
        compare("tgt_sr", e_sr[3:2], tgt_sr);
        compare("src_sr", e_sr[1:0], src_sr);
    endtask

    task automatic drive_row(input int k);
        pc    = vec_pc[k];
        instr = vec_instr[k];
        flush = vec_flush[k];
        stall = vec_stall[k];
    endtask

    initial begin
        iw_clk = 1'b0;
        forever #2 iw_clk = ~iw_clk;
    end

    initial begin
        #((n_rows + 20) * 4);
        $display("Timeout: the test sequence did not complete in time");
        $display("Finished with errors");
        $finish;
    end

    initial begin
        logic [addr_w-1:0] hold_pc;
        logic [23:0]       hold_instr;

        errors   = 0;
        checks   = 0;
        fill_idx = 0;
        seed     = 67661;
        iw_rst   = 1'b1;
        flush    = 1'b0;
        stall    = 1'b0;
        // Nonzero inputs while reset holds the register
        pc       = 16'hBEEF;
        instr    = 24'h015A3C;

        load_table();
        for (int k = 0; k < n_rows; k++) begin
            vec_pc[k] = $random(seed);
        end

        // pc and instr pass through, held by stall and cleared by flush
        hold_pc    = '0;
        hold_instr = '0;
        for (int k = 0; k < n_rows; k++) begin
            if (vec_flush[k]) begin
                hold_pc    = '0;
                hold_instr = '0;
            end else if (!vec_stall[k]) begin
                hold_pc    = vec_pc[k];
                hold_instr = vec_instr[k];
            end
            exp_pc[k]    = hold_pc;
            exp_instr[k] = hold_instr;
        end

        repeat (4) @(posedge iw_clk);
        #1;
        check_outputs('0, '0, '0, '0, '0, '0, '0, '0);
        repeat (4) @(posedge iw_clk);
        #1;
        check_outputs('0, '0, '0, '0, '0, '0, '0, '0);
        iw_rst = 1'b0;

        for (int k = 0; k < n_rows; k++) begin
            drive_row(k);
            @(posedge iw_clk);
            #1;
            check_outputs(exp_pc[k], exp_instr[k], vec_flags[k], vec_imm12[k],
                          vec_imm14[k], vec_cc[k], vec_gp[k], vec_sr[k]);
        end

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
